/* design/exec_pkg.sv */
/*
 * shared definitions for the execute stage
 * word and condition code types, opcode, branch condition and state enums
 */
package exec_pkg;

   // multiplier bits retired per cycle, one of 1, 2 or 4
   localparam int MUL_STEP_BITS = 2;

   typedef logic [15:0] word_t;

   // same bit order as the mask in the cc clear/set instructions
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   typedef enum logic [4:0] {
      OP_NONE,
      // double operand
      OP_MOV, OP_CMP, OP_BIT, OP_BIC,
      OP_BIS, OP_ADD, OP_SUB, OP_XOR,
      // single operand
      OP_CLR, OP_COM, OP_INC, OP_DEC,
      OP_NEG, OP_ADC, OP_SBC, OP_TST,
      OP_ROR, OP_ROL, OP_ASR, OP_ASL,
      OP_SWAB,
      // cc clear/set groups
      OP_CCC, OP_SCC,
      OP_BRANCH,
      OP_MUL
   } exec_op_t;

   typedef enum logic [3:0] {
      BR_ALWAYS,
      BR_NE, BR_EQ,
      BR_GE, BR_LT, BR_GT, BR_LE,
      BR_PL, BR_MI,
      BR_HI, BR_LOS,
      BR_VC, BR_VS,
      BR_CC, BR_CS
   } br_cond_t;

   typedef enum logic [1:0] {
      EX_IDLE,
      EX_MUL_RUN,
      EX_MUL_DONE
   } exec_state_t;

endpackage

/* design/alu_dual.sv */
/*
 * double operand word datapath
 * mov, cmp, bit, bic, bis, add, sub, xor with their condition codes
 */
`timescale 1ns/1ps

module alu_dual (
   input  exec_pkg::exec_op_t op,
   input  exec_pkg::word_t    ss_data,
   input  exec_pkg::word_t    dd_data,
   input  exec_pkg::cc_t      cc,
   output exec_pkg::word_t    result,
   output exec_pkg::cc_t      new_cc
);
   import exec_pkg::*;

   word_t       sub_a;
   word_t       sub_b;
   logic [16:0] sum;
   logic [16:0] diff;
   logic        add_v;
   logic        sub_v;

   // one subtractor, cmp is ss - dd and sub is dd - ss
   assign sub_a = (op == OP_CMP) ? ss_data : dd_data;
   assign sub_b = (op == OP_CMP) ? dd_data : ss_data;
   assign diff = {1'b0, sub_a} - {1'b0, sub_b};
   assign sum = {1'b0, ss_data} + {1'b0, dd_data};

   // like signs in, other sign out
   assign add_v = ~(ss_data[15] ^ dd_data[15]) & (sum[15] ^ ss_data[15]);
   assign sub_v = (sub_a[15] ^ sub_b[15]) & (diff[15] ^ sub_a[15]);

   always_comb
   begin
      new_cc.v = 1'b0;
      new_cc.c = cc.c;
      case (op)
         OP_MOV: result = ss_data;
         OP_BIT: result = ss_data & dd_data;
         OP_BIC: result = ~ss_data & dd_data;
         OP_BIS: result = ss_data | dd_data;
         OP_XOR: result = ss_data ^ dd_data;
         OP_ADD:
         begin
            result = sum[15:0];
            new_cc.v = add_v;
            new_cc.c = sum[16];
         end
         OP_CMP, OP_SUB:
         begin
            // c is the borrow
            result = diff[15:0];
            new_cc.v = sub_v;
            new_cc.c = diff[16];
         end
         default: result = '0;
      endcase
      new_cc.n = result[15];
      new_cc.z = result == 16'h0000;
   end

endmodule

/* design/alu_single.sv */
/*
 * single operand word datapath
 * clr..asl, swab and the cc clear/set groups
 */
`timescale 1ns/1ps

module alu_single (
   input  exec_pkg::exec_op_t op,
   input  exec_pkg::word_t    dd_data,
   input  exec_pkg::cc_t      cc,
   input  logic [3:0]         isn_low,
   output exec_pkg::word_t    result,
   output exec_pkg::cc_t      new_cc
);
   import exec_pkg::*;

   word_t res;
   logic  v;
   logic  c;

   always_comb
   begin
      res = '0;
      v = cc.v;
      c = cc.c;
      case (op)
         OP_CLR:
         begin
            v = 1'b0;
            c = 1'b0;
         end
         OP_COM:
         begin
            res = ~dd_data;
            v = 1'b0;
            c = 1'b1;
         end
         OP_INC:
         begin
            res = dd_data + 16'd1;
            v = res == 16'h8000;
         end
         OP_DEC:
         begin
            res = dd_data - 16'd1;
            v = res == 16'h7fff;
         end
         OP_NEG:
         begin
            res = -dd_data;
            v = res == 16'h8000;
            c = res != 16'h0000;
         end
         OP_ADC:
         begin
            res = dd_data + {15'b0, cc.c};
            v = cc.c && res == 16'h8000;
            c = cc.c && res == 16'h0000;
         end
         OP_SBC:
         begin
            res = dd_data - {15'b0, cc.c};
            v = cc.c && res == 16'h7fff;
            c = cc.c && res == 16'hffff;
         end
         OP_TST, OP_SWAB:
         begin
            res = (op == OP_SWAB) ? {dd_data[7:0], dd_data[15:8]} : dd_data;
            v = 1'b0;
            c = 1'b0;
         end
         // rotates and shifts, v is n xor c
         OP_ROR, OP_ASR:
         begin
            res = {(op == OP_ROR) ? cc.c : dd_data[15], dd_data[15:1]};
            c = dd_data[0];
            v = res[15] ^ dd_data[0];
         end
         OP_ROL, OP_ASL:
         begin
            res = {dd_data[14:0], (op == OP_ROL) ? cc.c : 1'b0};
            c = dd_data[15];
            v = res[15] ^ dd_data[15];
         end
         default: res = '0;
      endcase
   end

   assign result = res;

   always_comb
   begin
      case (op)
         OP_CCC: new_cc = cc & ~isn_low;
         OP_SCC: new_cc = cc | isn_low;
         // swab flags come from the low byte
         OP_SWAB: new_cc = '{n: res[7], z: res[7:0] == 8'h00, v: v, c: c};
         default: new_cc = '{n: res[15], z: res == 16'h0000, v: v, c: c};
      endcase
   end

endmodule

/* design/branch_unit.sv */
/*
 * conditional branch evaluation and target adder
 */
`timescale 1ns/1ps

module branch_unit (
   input  exec_pkg::br_cond_t cond,
   input  exec_pkg::cc_t      cc,
   input  exec_pkg::word_t    pc,
   input  logic [7:0]         offset,
   output logic               taken,
   output exec_pkg::word_t    target
);
   import exec_pkg::*;

   logic lt;

   // word offset, sign extended and doubled
   assign target = pc + {{7{offset[7]}}, offset, 1'b0};

   // signed less than
   assign lt = cc.n ^ cc.v;

   always_comb
   begin
      case (cond)
         BR_NE: taken = ~cc.z;
         BR_EQ: taken = cc.z;
         BR_GE: taken = ~lt;
         BR_LT: taken = lt;
         BR_GT: taken = ~(cc.z | lt);
         BR_LE: taken = cc.z | lt;
         BR_PL: taken = ~cc.n;
         BR_MI: taken = cc.n;
         BR_HI: taken = ~(cc.c | cc.z);
         BR_LOS: taken = cc.c | cc.z;
         BR_VC: taken = ~cc.v;
         BR_VS: taken = cc.v;
         BR_CC: taken = ~cc.c;
         BR_CS: taken = cc.c;
         default: taken = 1'b1;
      endcase
   end

endmodule

/* design/mul_seq.sv */
/*
 * sequential signed 16x16 multiplier
 * shift and add on magnitudes, sign fixed on the last step, overflow flag
 */
`timescale 1ns/1ps

module mul_seq #(
   parameter int MUL_STEP_BITS = exec_pkg::MUL_STEP_BITS
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            start,
   input  exec_pkg::word_t multiplier,
   input  exec_pkg::word_t multiplicand,
   output exec_pkg::word_t product_hi,
   output exec_pkg::word_t product_lo,
   output logic            overflow,
   output logic            done
);
   import exec_pkg::*;

   localparam int STEPS = 16 / MUL_STEP_BITS;
   localparam int CNT_W = $clog2(STEPS);

   // high half is the partial sum, low half the unused multiplier bits
   logic [31:0]      acc;
   word_t            mcand_q;
   logic             neg_q;
   logic             busy;
   logic [CNT_W-1:0] cnt;
   word_t            a_mag;
   word_t            b_mag;
   logic [31:0]      step_in;
   word_t            step_mcand;
   logic [31:0]      step_out;
   logic [31:0]      signed_out;

   function automatic logic [31:0] mul_step(input logic [31:0] acc_in, input word_t mc);
      logic [16+MUL_STEP_BITS-1:0] sum;
      sum = {{MUL_STEP_BITS{1'b0}}, acc_in[31:16]};
      for (int i = 0; i < MUL_STEP_BITS; i++)
      begin
         if (acc_in[i])
            sum = sum + ({{MUL_STEP_BITS{1'b0}}, mc} << i);
      end
      return {sum, acc_in[15:MUL_STEP_BITS]};
   endfunction

   assign a_mag = multiplier[15] ? -multiplier : multiplier;
   assign b_mag = multiplicand[15] ? -multiplicand : multiplicand;

   // first step runs on the start cycle straight from the operands
   assign step_in = start ? {16'h0000, a_mag} : acc;
   assign step_mcand = start ? b_mag : mcand_q;
   assign step_out = mul_step(step_in, step_mcand);
   assign signed_out = neg_q ? -step_out : step_out;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy <= 1'b0;
         cnt <= '0;
         done <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (start)
         begin
            busy <= 1'b1;
            cnt <= CNT_W'(STEPS - 2);
         end
         else if (busy)
         begin
            if (cnt == '0)
            begin
               busy <= 1'b0;
               done <= 1'b1;
            end
            else
               cnt <= cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         acc <= step_out;
         mcand_q <= b_mag;
         neg_q <= multiplier[15] ^ multiplicand[15];
      end
      else if (busy)
      begin
         if (cnt == '0)
         begin
            acc <= signed_out;
            // upper 17 bits must all match to fit in 16 signed
            overflow <= !(&signed_out[31:15] || ~|signed_out[31:15]);
         end
         else
            acc <= step_out;
      end
   end

   assign product_hi = acc[31:16];
   assign product_lo = acc[15:0];

endmodule

/* design/exec_control.sv */
/*
 * execute control
 * isn decode, mul sequencing FSM, selection of results, cc and strobes
 */
`timescale 1ns/1ps

module exec_control (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enable,
   input  exec_pkg::word_t    isn,
   input  exec_pkg::cc_t      cc,
   input  exec_pkg::word_t    dual_result,
   input  exec_pkg::word_t    single_result,
   input  exec_pkg::word_t    product_hi,
   input  exec_pkg::word_t    product_lo,
   input  exec_pkg::cc_t      dual_cc,
   input  exec_pkg::cc_t      single_cc,
   input  exec_pkg::cc_t      mul_cc,
   input  logic               branch_taken,
   input  exec_pkg::word_t    branch_pc,
   input  logic               mul_done,
   output exec_pkg::exec_op_t op,
   output exec_pkg::br_cond_t cond,
   output logic               mul_start,
   output exec_pkg::word_t    e1_result,
   output exec_pkg::word_t    e32_result,
   output exec_pkg::word_t    new_pc,
   output exec_pkg::cc_t      new_cc,
   output logic               latch_pc,
   output logic               latch_cc,
   output logic               advance
);
   import exec_pkg::*;

   exec_state_t state;
   exec_state_t state_nxt;
   cc_t         mul_flags;
   logic        mul_ready;

   // decode on the octal fields of the isn
   always_comb
   begin
      op = OP_NONE;
      case (isn[15:12])
         4'o01: op = OP_MOV;
         4'o02: op = OP_CMP;
         4'o03: op = OP_BIT;
         4'o04: op = OP_BIC;
         4'o05: op = OP_BIS;
         4'o06: op = OP_ADD;
         4'o16: op = OP_SUB;
         4'o07:
            if (isn[11:9] == 3'o0)
               op = OP_MUL;
            else if (isn[11:9] == 3'o4)
               op = OP_XOR;
         4'o00:
            // 000400-003777 are branches
            if (!isn[11] && isn[10:8] != 3'o0)
               op = OP_BRANCH;
            else
               case (isn[11:6])
                  6'o02:
                     if (isn[5:4] == 2'b10)
                        op = OP_CCC;
                     else if (isn[5:4] == 2'b11)
                        op = OP_SCC;
                  6'o03: op = OP_SWAB;
                  6'o50: op = OP_CLR;
                  6'o51: op = OP_COM;
                  6'o52: op = OP_INC;
                  6'o53: op = OP_DEC;
                  6'o54: op = OP_NEG;
                  6'o55: op = OP_ADC;
                  6'o56: op = OP_SBC;
                  6'o57: op = OP_TST;
                  6'o60: op = OP_ROR;
                  6'o61: op = OP_ROL;
                  6'o62: op = OP_ASR;
                  6'o63: op = OP_ASL;
                  default: op = OP_NONE;
               endcase
         4'o10:
            if (!isn[11])
               op = OP_BRANCH;
         default: op = OP_NONE;
      endcase
   end

   // isn[15] picks the bank, isn[10:8] the pair; 0001 is br
   always_comb
   begin
      case ({isn[15], isn[10:8]})
         4'b0010: cond = BR_NE;
         4'b0011: cond = BR_EQ;
         4'b0100: cond = BR_GE;
         4'b0101: cond = BR_LT;
         4'b0110: cond = BR_GT;
         4'b0111: cond = BR_LE;
         4'b1000: cond = BR_PL;
         4'b1001: cond = BR_MI;
         4'b1010: cond = BR_HI;
         4'b1011: cond = BR_LOS;
         4'b1100: cond = BR_VC;
         4'b1101: cond = BR_VS;
         4'b1110: cond = BR_CC;
         4'b1111: cond = BR_CS;
         default: cond = BR_ALWAYS;
      endcase
   end

   assign mul_start = enable && op == OP_MUL && state == EX_IDLE;
   assign mul_ready = state == EX_MUL_DONE;

   always_comb
   begin
      state_nxt = state;
      case (state)
         EX_IDLE:
            if (mul_start)
               state_nxt = EX_MUL_RUN;
         EX_MUL_RUN:
            if (mul_done)
               state_nxt = EX_MUL_DONE;
         default: state_nxt = EX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= EX_IDLE;
      else
         state <= state_nxt;
   end

   // multiplier overflow comes in on the c bit of mul_cc
   assign mul_flags = '{n: product_hi[15],
                        z: {product_hi, product_lo} == 32'h0,
                        v: 1'b0,
                        c: mul_cc.c};

   always_comb
   begin
      e1_result = '0;
      e32_result = '0;
      new_pc = '0;
      new_cc = '0;
      latch_pc = 1'b0;
      latch_cc = 1'b0;
      advance = 1'b0;
      if (enable)
      begin
         new_cc = cc;
         advance = 1'b1;
         case (op)
            OP_MOV, OP_CMP, OP_BIT, OP_BIC, OP_BIS, OP_ADD, OP_SUB, OP_XOR:
            begin
               e1_result = dual_result;
               new_cc = dual_cc;
               latch_cc = 1'b1;
            end
            OP_CLR, OP_COM, OP_INC, OP_DEC, OP_NEG, OP_ADC, OP_SBC, OP_TST,
            OP_ROR, OP_ROL, OP_ASR, OP_ASL, OP_SWAB, OP_CCC, OP_SCC:
            begin
               e1_result = single_result;
               new_cc = single_cc;
               latch_cc = 1'b1;
            end
            OP_BRANCH:
            begin
               new_pc = branch_pc;
               latch_pc = branch_taken;
            end
            OP_MUL:
            begin
               e32_result = product_hi;
               e1_result = product_lo;
               new_cc = mul_flags;
               latch_cc = mul_ready;
               advance = mul_ready;
            end
            // undecoded, passes through with nothing latched
            default: ;
         endcase
      end
   end

endmodule

/* design/exec_top.sv */
/*
 * execute stage top level
 * control, word datapaths, branch unit and multiplier
 */
`timescale 1ns/1ps

module exec_top #(
   parameter int MUL_STEP_BITS = exec_pkg::MUL_STEP_BITS
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            enable,
   input  exec_pkg::word_t isn,
   input  exec_pkg::word_t pc,
   input  exec_pkg::word_t ss_data,
   input  exec_pkg::word_t dd_data,
   input  exec_pkg::cc_t   cc,
   output exec_pkg::word_t e1_result,
   output exec_pkg::word_t e32_result,
   output exec_pkg::word_t new_pc,
   output logic            latch_pc,
   output exec_pkg::cc_t   new_cc,
   output logic            latch_cc,
   output logic            advance
);

   exec_pkg::exec_op_t op;
   exec_pkg::br_cond_t cond;
   exec_pkg::word_t    dual_result;
   exec_pkg::cc_t      dual_cc;
   exec_pkg::word_t    single_result;
   exec_pkg::cc_t      single_cc;
   logic               branch_taken;
   exec_pkg::word_t    branch_pc;
   logic               mul_start;
   logic               mul_done;
   logic               mul_overflow;
   exec_pkg::word_t    mul_hi;
   exec_pkg::word_t    mul_lo;

   exec_control u_control (
      .clk(clk), .rst_n(rst_n), .enable(enable), .isn(isn), .cc(cc),
      .dual_result(dual_result), .single_result(single_result),
      .product_hi(mul_hi), .product_lo(mul_lo),
      .dual_cc(dual_cc), .single_cc(single_cc),
      // overflow rides on the c bit
      .mul_cc({3'b000, mul_overflow}),
      .branch_taken(branch_taken), .branch_pc(branch_pc), .mul_done(mul_done),
      .op(op), .cond(cond), .mul_start(mul_start),
      .e1_result(e1_result), .e32_result(e32_result), .new_pc(new_pc),
      .new_cc(new_cc), .latch_pc(latch_pc), .latch_cc(latch_cc), .advance(advance)
   );

   alu_dual u_alu_dual (
      .op(op), .ss_data(ss_data), .dd_data(dd_data), .cc(cc),
      .result(dual_result), .new_cc(dual_cc)
   );

   alu_single u_alu_single (
      .op(op), .dd_data(dd_data), .cc(cc), .isn_low(isn[3:0]),
      .result(single_result), .new_cc(single_cc)
   );

   branch_unit u_branch (
      .cond(cond), .cc(cc), .pc(pc), .offset(isn[7:0]),
      .taken(branch_taken), .target(branch_pc)
   );

   mul_seq #(
      .MUL_STEP_BITS(MUL_STEP_BITS)
   ) u_mul (
      .clk(clk), .rst_n(rst_n), .start(mul_start),
      .multiplier(ss_data), .multiplicand(dd_data),
      .product_hi(mul_hi), .product_lo(mul_lo),
      .overflow(mul_overflow), .done(mul_done)
   );

endmodule

/* bench/tb_clock.sv */
/*
 * testbench clock source, free running from time zero
 */
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS = 40
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* bench/tb_exec.sv */
/*
 * testbench for the execute stage
 * xorshift stimulus, reference model of the kept instructions,
 * value check task and pass/fail reporting
 */
`timescale 1ns/1ps

module tb_exec;

   localparam int WAIT_LIMIT = 64;
   localparam int N_DUAL = 300;
   localparam int N_SINGLE = 300;
   localparam int N_CC = 60;
   localparam int N_BRANCH = 300;
   localparam int N_MUL = 60;
   localparam int N_MIXED = 400;

   logic        clk;
   logic        rst_n;
   logic        enable;
   logic [15:0] isn;
   logic [15:0] pc;
   logic [15:0] ss_data;
   logic [15:0] dd_data;
   logic [3:0]  cc;
   logic [15:0] e1_result;
   logic [15:0] e32_result;
   logic [15:0] new_pc;
   logic        latch_pc;
   logic [3:0]  new_cc;
   logic        latch_cc;
   logic        advance;

   // next instruction and what the model expects of it
   logic [15:0] s_isn;
   logic [15:0] s_pc;
   logic [15:0] s_ss;
   logic [15:0] s_dd;
   logic [3:0]  s_cc;
   logic [15:0] exp_e1;
   logic [15:0] exp_e32;
   logic [15:0] exp_pc;
   logic [3:0]  exp_cc;
   logic        exp_latch_pc;
   logic        exp_latch_cc;
   logic        exp_multi;

   logic [31:0] rng;
   int          checks;

   tb_clock #(
      .PERIOD_NS(40)
   ) u_clock (
      .clk(clk)
   );

   exec_top DUT (
      .clk(clk), .rst_n(rst_n), .enable(enable), .isn(isn), .pc(pc),
      .ss_data(ss_data), .dd_data(dd_data), .cc(cc),
      .e1_result(e1_result), .e32_result(e32_result), .new_pc(new_pc),
      .latch_pc(latch_pc), .new_cc(new_cc), .latch_cc(latch_cc), .advance(advance)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // mostly random with the usual corner values now and then
   function automatic logic [15:0] pick_operand(input logic [31:0] r);
      case (r[19:16])
         4'd0: return 16'h0000;
         4'd1: return 16'h7fff;
         4'd2: return 16'h8000;
         4'd3: return 16'hffff;
         default: return r[15:0];
      endcase
   endfunction

   function automatic logic [15:0] mul_operand(input logic [31:0] r);
      case (r[21:20])
         2'd0: return r[15:0];
         2'd1: return {{8{r[7]}}, r[7:0]};
         2'd2: return pick_operand(r);
         default: return {{4{r[11]}}, r[11:0]};
      endcase
   endfunction

   // returns {result, n, z, v, c}
   // idx selects mov cmp bit bic bis add sub xor
   function automatic logic [19:0] model_dual(input int idx, input logic [15:0] s,
                                              input logic [15:0] d, input logic [3:0] c);
      logic [15:0] r;
      logic        v_f;
      logic        c_f;
      r = 16'h0000;
      v_f = 1'b0;
      c_f = c[0];
      case (idx)
         0: r = s;
         1:
         begin
            r = s - d;
            v_f = (s[15] != d[15]) && (r[15] != s[15]);
            c_f = s < d;
         end
         2: r = s & d;
         3: r = d & ~s;
         4: r = s | d;
         5:
         begin
            {c_f, r} = {1'b0, s} + {1'b0, d};
            v_f = (s[15] == d[15]) && (r[15] != s[15]);
         end
         6:
         begin
            r = d - s;
            v_f = (s[15] != d[15]) && (r[15] != d[15]);
            c_f = d < s;
         end
         default: r = s ^ d;
      endcase
      return {r, r[15], r == 16'h0000, v_f, c_f};
   endfunction

   // idx selects clr com inc dec neg adc sbc tst ror rol asr asl swab
   function automatic logic [19:0] model_single(input int idx, input logic [15:0] d,
                                                input logic [3:0] c);
      logic [15:0] r;
      logic        v_f;
      logic        c_f;
      r = 16'h0000;
      v_f = c[1];
      c_f = c[0];
      case (idx)
         0:
         begin
            v_f = 1'b0;
            c_f = 1'b0;
         end
         1:
         begin
            r = ~d;
            v_f = 1'b0;
            c_f = 1'b1;
         end
         2:
         begin
            r = d + 16'd1;
            v_f = d == 16'h7fff;
         end
         3:
         begin
            r = d - 16'd1;
            v_f = d == 16'h8000;
         end
         4:
         begin
            r = 16'h0000 - d;
            v_f = d == 16'h8000;
            c_f = d != 16'h0000;
         end
         5:
         begin
            r = d + {15'b0, c[0]};
            v_f = c[0] && d == 16'h7fff;
            c_f = c[0] && d == 16'hffff;
         end
         6:
         begin
            // borrow out of zero
            r = d - {15'b0, c[0]};
            v_f = c[0] && d == 16'h8000;
            c_f = c[0] && d == 16'h0000;
         end
         7:
         begin
            r = d;
            v_f = 1'b0;
            c_f = 1'b0;
         end
         8:
         begin
            r = {c[0], d[15:1]};
            c_f = d[0];
         end
         9:
         begin
            r = {d[14:0], c[0]};
            c_f = d[15];
         end
         10:
         begin
            r = {d[15], d[15:1]};
            c_f = d[0];
         end
         11:
         begin
            r = {d[14:0], 1'b0};
            c_f = d[15];
         end
         default:
         begin
            r = {d[7:0], d[15:8]};
            return {r, r[7], r[7:0] == 8'h00, 1'b0, 1'b0};
         end
      endcase
      if (idx >= 8)
         v_f = r[15] ^ c_f;
      return {r, r[15], r == 16'h0000, v_f, c_f};
   endfunction

   function automatic logic branch_cond(input logic bank, input logic [2:0] sel,
                                        input logic [3:0] c);
      logic n_f;
      logic z_f;
      logic v_f;
      logic c_f;
      n_f = c[3];
      z_f = c[2];
      v_f = c[1];
      c_f = c[0];
      case ({bank, sel})
         4'b0001: return 1'b1;
         4'b0010: return !z_f;
         4'b0011: return z_f;
         4'b0100: return (n_f == v_f);
         4'b0101: return (n_f != v_f);
         4'b0110: return !z_f && (n_f == v_f);
         4'b0111: return z_f || (n_f != v_f);
         4'b1000: return !n_f;
         4'b1001: return n_f;
         4'b1010: return !c_f && !z_f;
         4'b1011: return c_f || z_f;
         4'b1100: return !v_f;
         4'b1101: return v_f;
         4'b1110: return !c_f;
         4'b1111: return c_f;
         default: return 1'b0;
      endcase
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t ns: %s wrong for isn %06o, got %h expected %h",
                  $time, what, s_isn, actual, expected);
         $display("TB FAILED");
         $fatal(1, "output mismatch");
      end
   endtask

   // with enable low every output is quiet
   task automatic check_idle();
      check_value(32'(advance), 32'd0, "advance while idle");
      check_value(32'(latch_pc), 32'd0, "latch_pc while idle");
      check_value(32'(latch_cc), 32'd0, "latch_cc while idle");
      check_value(32'(e1_result), 32'd0, "e1_result while idle");
      check_value(32'(e32_result), 32'd0, "e32_result while idle");
      check_value(32'(new_pc), 32'd0, "new_pc while idle");
      check_value(32'(new_cc), 32'd0, "new_cc while idle");
   endtask

   task automatic clear_expect();
      s_pc = 16'(next_rand()) & 16'hfffe;
      s_ss = 16'(next_rand());
      s_dd = 16'(next_rand());
      s_cc = 4'(next_rand());
      exp_e1 = 16'h0000;
      exp_e32 = 16'h0000;
      exp_pc = 16'h0000;
      exp_cc = 4'h0;
      exp_latch_pc = 1'b0;
      exp_latch_cc = 1'b1;
      exp_multi = 1'b0;
   endtask

   task automatic make_dual();
      logic [31:0] r;
      logic [19:0] m;
      logic [3:0]  code;
      int          idx;
      clear_expect();
      r = next_rand();
      idx = int'(r[18:16]);
      s_ss = pick_operand(next_rand());
      s_dd = pick_operand(next_rand());
      case (idx)
         0: code = 4'o01;
         1: code = 4'o02;
         2: code = 4'o03;
         3: code = 4'o04;
         4: code = 4'o05;
         5: code = 4'o06;
         default: code = 4'o16;
      endcase
      if (idx == 7)
         s_isn = {4'o07, 3'o4, r[8:0]};
      else
         s_isn = {code, r[11:0]};
      m = model_dual(idx, s_ss, s_dd, s_cc);
      exp_e1 = m[19:4];
      exp_cc = m[3:0];
   endtask

   task automatic make_single();
      logic [31:0] r;
      logic [19:0] m;
      logic [5:0]  code;
      int          idx;
      clear_expect();
      r = next_rand();
      idx = int'(r[27:24]) % 13;
      s_dd = pick_operand(next_rand());
      // single operand codes run 0050 to 0063 and swab is 0003
      code = (idx == 12) ? 6'o03 : 6'(40 + idx);
      s_isn = {4'h0, code, r[5:0]};
      m = model_single(idx, s_dd, s_cc);
      exp_e1 = m[19:4];
      exp_cc = m[3:0];
   endtask

   task automatic make_cc_op();
      logic [31:0] r;
      clear_expect();
      r = next_rand();
      s_isn = {4'h0, 6'o02, 1'b1, r[4], r[3:0]};
      if (r[4])
         exp_cc = s_cc | r[3:0];
      else
         exp_cc = s_cc & ~r[3:0];
   endtask

   task automatic make_branch();
      logic [31:0] r;
      logic [15:0] off_ext;
      logic [2:0]  sel;
      clear_expect();
      r = next_rand();
      sel = r[10:8];
      // 000000 through 000377 are not branches
      if (!r[16] && sel == 3'd0)
         sel = 3'd1;
      s_isn = {r[16], 4'b0000, sel, r[7:0]};
      off_ext = {{8{r[7]}}, r[7:0]};
      exp_pc = s_pc + (off_ext << 1);
      exp_latch_pc = branch_cond(r[16], sel, s_cc);
      exp_latch_cc = 1'b0;
      exp_cc = s_cc;
   endtask

   task automatic make_mul();
      logic [31:0]        r;
      logic signed [31:0] prod;
      logic               ovf;
      clear_expect();
      r = next_rand();
      s_ss = mul_operand(next_rand());
      s_dd = mul_operand(next_rand());
      s_isn = {4'o07, 3'o0, r[8:0]};
      prod = 32'($signed(s_ss)) * 32'($signed(s_dd));
      ovf = (prod > 32'sd32767) || (prod < -32'sd32768);
      exp_e32 = prod[31:16];
      exp_e1 = prod[15:0];
      exp_cc = {prod[31], prod == 32'sd0, 1'b0, ovf};
      exp_multi = 1'b1;
   endtask

   task automatic drive_and_check();
      int waited;
      waited = 0;
      @(posedge clk);
      enable <= 1'b1;
      isn <= s_isn;
      pc <= s_pc;
      ss_data <= s_ss;
      dd_data <= s_dd;
      cc <= s_cc;
      @(negedge clk);
      while (!advance)
      begin
         if (waited >= WAIT_LIMIT)
         begin
            $display("advance never came within %0d cycles for isn %06o", WAIT_LIMIT, s_isn);
            $display("TB FAILED");
            $fatal(1, "advance timeout");
         end
         else
         begin
            waited++;
            @(negedge clk);
         end
      end
      // everything but mul completes in the enable cycle
      if (!exp_multi)
         check_value(32'(waited), 32'd0, "advance latency");
      check_value(32'(e1_result), 32'(exp_e1), "e1_result");
      check_value(32'(e32_result), 32'(exp_e32), "e32_result");
      check_value(32'(latch_pc), 32'(exp_latch_pc), "latch_pc");
      if (latch_pc)
         check_value(32'(new_pc), 32'(exp_pc), "new_pc");
      check_value(32'(new_cc), 32'(exp_cc), "new_cc");
      check_value(32'(latch_cc), 32'(exp_latch_cc), "latch_cc");
      checks++;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      enable <= 1'b0;
      @(negedge clk);
      check_idle();
   endtask

   initial
   begin
      logic [31:0] r;
      rng = 32'd5;
      checks = 0;
      rst_n = 1'b0;
      enable = 1'b0;
      isn = 16'h0000;
      pc = 16'h0000;
      ss_data = 16'h0000;
      dd_data = 16'h0000;
      cc = 4'h0;
      s_isn = 16'h0000;

      for (int i = 0; i < 8; i++)
      begin
         @(posedge clk);
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      idle_cycle();
      idle_cycle();

      for (int i = 0; i < N_DUAL; i++)
      begin
         make_dual();
         drive_and_check();
      end
      for (int i = 0; i < N_SINGLE; i++)
      begin
         make_single();
         drive_and_check();
      end
      for (int i = 0; i < N_CC; i++)
      begin
         make_cc_op();
         drive_and_check();
      end
      for (int i = 0; i < N_BRANCH; i++)
      begin
         make_branch();
         drive_and_check();
      end
      // mul after mul with no gap between them
      for (int i = 0; i < N_MUL; i++)
      begin
         make_mul();
         drive_and_check();
      end
      idle_cycle();

      for (int i = 0; i < N_MIXED; i++)
      begin
         r = next_rand();
         if (r[31:29] == 3'd0)
            idle_cycle();
         case (r[2:0])
            3'd0, 3'd6: make_dual();
            3'd1: make_single();
            3'd2: make_cc_op();
            3'd3: make_branch();
            default: make_mul();
         endcase
         drive_and_check();
      end

      idle_cycle();
      $display("%0d instructions checked", checks);
      $display("TB PASSED");
      $finish;
   end

endmodule

/* src.f */
design/exec_pkg.sv
design/alu_dual.sv
design/alu_single.sv
design/branch_unit.sv
design/mul_seq.sv
design/exec_control.sv
design/exec_top.sv
bench/tb_clock.sv
bench/tb_exec.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_exec -f src.f
	./obj_dir/Vtb_exec | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
